// ==== logic/ocl_bus_pkg.sv ====
package ocl_bus_pkg;

  // ----------------------------------------
  // Bus field widths
  // ----------------------------------------
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;
  localparam int unsigned RESP_WIDTH = 2;
  localparam int unsigned LED_WIDTH  = 16;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  // One strobe per byte lane
  typedef logic [STRB_WIDTH-1:0] strb_t;
  typedef logic [RESP_WIDTH-1:0] resp_t;
  // Virtual LED and DIP switch vector
  typedef logic [LED_WIDTH-1:0]  led_t;

  // Only response ever returned
  localparam resp_t RESP_OKAY = 2'b00;

  // ----------------------------------------
  // Register map, byte addresses
  // ----------------------------------------
  // Hello-world block
  localparam addr_t HELLO_WORLD_REG_ADDR = 32'h0000_0500;
  localparam addr_t VLED_REG_ADDR        = 32'h0000_0504;

  // Counter block
  localparam addr_t CNT_CTRL_REG_ADDR    = 32'h0000_0510;
  localparam addr_t CNT_TICK_REG_ADDR    = 32'h0000_0514;
  localparam addr_t CNT_LOAD_REG_ADDR    = 32'h0000_0518;
  localparam addr_t CNT_WMARK_REG_ADDR   = 32'h0000_051C;
  localparam addr_t CNT_STATUS_REG_ADDR  = 32'h0000_0520;

  // Read value for any address outside the map
  localparam data_t UNIMPLEMENTED_REG_VALUE = 32'hDEAD_BEEF;

endpackage

// ==== logic/counter_pkg.sv ====
package counter_pkg;

  // ----------------------------------------
  // Counter widths
  // ----------------------------------------
  localparam int unsigned CNT_WIDTH  = 16;
  localparam int unsigned TICK_WIDTH = 8;
  localparam int unsigned CTRL_WIDTH = 4;

  // Main counter, load value, watermark
  typedef logic [CNT_WIDTH-1:0]  count_t;
  // Prescaler count and tick value
  typedef logic [TICK_WIDTH-1:0] tick_t;

  // Saturation point in one-shot mode
  localparam count_t COUNT_MAX = 16'hFFFF;

  // ----------------------------------------
  // Control register bits
  // ----------------------------------------
  localparam int unsigned CTRL_ENABLE_BIT  = 0;
  localparam int unsigned CTRL_LOAD_BIT    = 1;
  localparam int unsigned CTRL_CLEAR_BIT   = 2;
  localparam int unsigned CTRL_ONESHOT_BIT = 3;

  // Status register layout, unused bits read zero
  localparam int unsigned STATUS_CNT_LSB      = 0;
  localparam int unsigned STATUS_TICK_CNT_LSB = 16;
  localparam int unsigned STATUS_TICK_BIT     = 24;
  localparam int unsigned STATUS_WMARK_BIT    = 25;

endpackage

// ==== logic/ocl_slave.sv ====
`timescale 1ns/1ps

module ocl_slave (
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,
  // Write address channel
  input  logic                  awvalid,
  input  ocl_bus_pkg::addr_t    awaddr,
  output logic                  awready,
  // Write data channel
  input  logic                  wvalid,
  input  ocl_bus_pkg::data_t    wdata,
  input  ocl_bus_pkg::strb_t    wstrb,
  output logic                  wready,
  // Write response channel
  output logic                  bvalid,
  output ocl_bus_pkg::resp_t    bresp,
  input  logic                  bready,
  // Read address channel
  input  logic                  arvalid,
  input  ocl_bus_pkg::addr_t    araddr,
  output logic                  arready,
  // Read data channel
  output logic                  rvalid,
  output ocl_bus_pkg::data_t    rdata,
  output ocl_bus_pkg::resp_t    rresp,
  input  logic                  rready,
  // Register side
  output logic                  wr_en,
  output ocl_bus_pkg::addr_t    wr_addr,
  output ocl_bus_pkg::data_t    wr_data,
  output ocl_bus_pkg::addr_t    rd_addr,
  input  ocl_bus_pkg::data_t    regs_rd_data,
  input  logic                  regs_rd_hit,
  input  ocl_bus_pkg::data_t    cnt_rd_data,
  input  logic                  cnt_rd_hit
);

  // Write side, address then data then response
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  // Read side, one wait cycle before data
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_PEND,
    RD_RESP
  } rd_state_e;

  wr_state_e          wr_state_q;
  wr_state_e          wr_state_next;
  rd_state_e          rd_state_q;
  rd_state_e          rd_state_next;
  ocl_bus_pkg::data_t rd_mux;

  // ----------------------------------------
  // Write handshake
  // ----------------------------------------
  always_comb begin
    wr_state_next = wr_state_q;
    case (wr_state_q)
      WR_IDLE: begin
        if (awvalid) begin
          wr_state_next = WR_DATA;
        end
      end
      // Data beat is the write edge
      WR_DATA: begin
        if (wvalid) begin
          wr_state_next = WR_RESP;
        end
      end
      // Held under response back-pressure
      WR_RESP: begin
        if (bready) begin
          wr_state_next = WR_IDLE;
        end
      end
      default: begin
        wr_state_next = WR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_state_q <= WR_IDLE;
    end else begin
      wr_state_q <= wr_state_next;
    end
  end

  // Address held for the whole write
  always_ff @(posedge clk_main_a0) begin
    if (awvalid && awready) begin
      wr_addr <= awaddr;
    end
  end

  assign awready = (wr_state_q == WR_IDLE);
  assign wready  = (wr_state_q == WR_DATA) && wvalid;
  assign bvalid  = (wr_state_q == WR_RESP);
  assign bresp   = ocl_bus_pkg::RESP_OKAY;

  // Register update strobe, data passed straight through
  // Byte strobes are not decoded, every write is a full word
  assign wr_en   = wready;
  assign wr_data = wdata;

  // ----------------------------------------
  // Read handshake
  // ----------------------------------------
  always_comb begin
    rd_state_next = rd_state_q;
    case (rd_state_q)
      RD_IDLE: begin
        if (arvalid) begin
          rd_state_next = RD_PEND;
        end
      end
      RD_PEND: begin
        rd_state_next = RD_RESP;
      end
      RD_RESP: begin
        if (rready) begin
          rd_state_next = RD_IDLE;
        end
      end
      default: begin
        rd_state_next = RD_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_state_q <= RD_IDLE;
    end else begin
      rd_state_q <= rd_state_next;
    end
  end

  // Captured only on an accepted read
  always_ff @(posedge clk_main_a0) begin
    if (arvalid && arready) begin
      rd_addr <= araddr;
    end
  end

  // Hello-world block wins, then counter, then fallback
  always_comb begin
    if (regs_rd_hit) begin
      rd_mux = regs_rd_data;
    end else if (cnt_rd_hit) begin
      rd_mux = cnt_rd_data;
    end else begin
      rd_mux = ocl_bus_pkg::UNIMPLEMENTED_REG_VALUE;
    end
  end

  // Data stable while rvalid waits, zero when idle
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rdata <= '0;
    end else if (rd_state_q == RD_PEND) begin
      rdata <= rd_mux;
    end else if (rvalid && rready) begin
      rdata <= '0;
    end
  end

  assign arready = (rd_state_q == RD_IDLE);
  assign rvalid  = (rd_state_q == RD_RESP);
  assign rresp   = ocl_bus_pkg::RESP_OKAY;

endmodule

// ==== logic/hello_world_regs.sv ====
`timescale 1ns/1ps

module hello_world_regs #(
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic               clk_main_a0,
  input  logic               rst_main_n_sync,
  input  logic               wr_en,
  input  ocl_bus_pkg::addr_t wr_addr,
  input  ocl_bus_pkg::data_t wr_data,
  input  ocl_bus_pkg::addr_t rd_addr,
  output ocl_bus_pkg::data_t rd_data,
  output logic               rd_hit,
  input  ocl_bus_pkg::led_t  vdip,
  output ocl_bus_pkg::led_t  vled
);

  ocl_bus_pkg::data_t hello_world_q;
  ocl_bus_pkg::data_t hello_world_swapped;
  ocl_bus_pkg::led_t  vled_shadow_q;
  ocl_bus_pkg::led_t  vdip_sync_q [SYNC_STAGES];

  // ----------------------------------------
  // Hello-world register
  // ----------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_world_q <= '0;
    end else if (wr_en && (wr_addr == ocl_bus_pkg::HELLO_WORLD_REG_ADDR)) begin
      hello_world_q <= wr_data;
    end
  end

  // Reads back with byte order reversed
  assign hello_world_swapped = {
    hello_world_q[7:0],
    hello_world_q[15:8],
    hello_world_q[23:16],
    hello_world_q[31:24]
  };

  // ----------------------------------------
  // Virtual LED path
  // ----------------------------------------
  // Low half of the hello-world register, one cycle late
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_shadow_q <= '0;
    end else begin
      vled_shadow_q <= hello_world_q[15:0];
    end
  end

  // DIP switches arrive from another domain
  // First stage samples the raw input
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        vdip_sync_q[i] <= '0;
      end
    end else begin
      vdip_sync_q[0] <= vdip;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        vdip_sync_q[i] <= vdip_sync_q[i-1];
      end
    end
  end

  // Switch off clears its LED
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled <= '0;
    end else begin
      vled <= vled_shadow_q & vdip_sync_q[SYNC_STAGES-1];
    end
  end

  // ----------------------------------------
  // Readback
  // ----------------------------------------
  always_comb begin
    rd_data = '0;
    rd_hit  = 1'b1;
    if (rd_addr == ocl_bus_pkg::HELLO_WORLD_REG_ADDR) begin
      rd_data = hello_world_swapped;
    end else if (rd_addr == ocl_bus_pkg::VLED_REG_ADDR) begin
      // Shadow value, zero-extended
      rd_data = ocl_bus_pkg::data_t'(vled_shadow_q);
    end else begin
      rd_hit = 1'b0;
    end
  end

endmodule

// ==== logic/tick_counter.sv ====
`timescale 1ns/1ps

module tick_counter (
  input  logic               clk_main_a0,
  input  logic               rst_main_n_sync,
  input  logic               wr_en,
  input  ocl_bus_pkg::addr_t wr_addr,
  input  ocl_bus_pkg::data_t wr_data,
  input  ocl_bus_pkg::addr_t rd_addr,
  output ocl_bus_pkg::data_t rd_data,
  output logic               rd_hit
);

  logic [counter_pkg::CTRL_WIDTH-1:0] ctrl_q;
  counter_pkg::tick_t                 tick_value_q;
  counter_pkg::count_t                load_value_q;
  counter_pkg::count_t                wmark_q;

  counter_pkg::tick_t                 tick_cnt_q;
  counter_pkg::tick_t                 tick_cnt_next;
  counter_pkg::count_t                cnt_q;
  counter_pkg::count_t                cnt_next;
  ocl_bus_pkg::data_t                 status_q;
  ocl_bus_pkg::data_t                 status_next;

  logic cnt_enable;
  logic cnt_load;
  logic cnt_clear;
  logic cnt_oneshot;
  logic tick;

  // ----------------------------------------
  // Configuration registers
  // ----------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ctrl_q       <= '0;
      tick_value_q <= '0;
      load_value_q <= '0;
      wmark_q      <= '0;
    end else if (wr_en) begin
      case (wr_addr)
        ocl_bus_pkg::CNT_CTRL_REG_ADDR:  ctrl_q       <= wr_data[counter_pkg::CTRL_WIDTH-1:0];
        ocl_bus_pkg::CNT_TICK_REG_ADDR:  tick_value_q <= wr_data[counter_pkg::TICK_WIDTH-1:0];
        ocl_bus_pkg::CNT_LOAD_REG_ADDR:  load_value_q <= wr_data[counter_pkg::CNT_WIDTH-1:0];
        ocl_bus_pkg::CNT_WMARK_REG_ADDR: wmark_q      <= wr_data[counter_pkg::CNT_WIDTH-1:0];
        default: begin
        end
      endcase
    end
  end

  assign cnt_enable  = ctrl_q[counter_pkg::CTRL_ENABLE_BIT];
  assign cnt_load    = ctrl_q[counter_pkg::CTRL_LOAD_BIT];
  assign cnt_clear   = ctrl_q[counter_pkg::CTRL_CLEAR_BIT];
  assign cnt_oneshot = ctrl_q[counter_pkg::CTRL_ONESHOT_BIT];

  // ----------------------------------------
  // Prescaler and main counter
  // ----------------------------------------
  // Tick decided on the count before this cycle's update
  assign tick = (tick_cnt_q >= tick_value_q);

  always_comb begin
    if (cnt_clear) begin
      tick_cnt_next = '0;
    end else if (!cnt_enable) begin
      tick_cnt_next = tick_cnt_q;
    end else if (tick) begin
      tick_cnt_next = '0;
    end else begin
      tick_cnt_next = tick_cnt_q + 1'b1;
    end
  end

  // Clear beats load, load beats enable
  always_comb begin
    cnt_next = cnt_q;
    if (cnt_clear) begin
      cnt_next = '0;
    end else if (cnt_load) begin
      cnt_next = load_value_q;
    end else if (cnt_enable && tick) begin
      // One-shot saturates at the top
      if (!(cnt_oneshot && (cnt_q == counter_pkg::COUNT_MAX))) begin
        cnt_next = cnt_q + 1'b1;
      end
    end
  end

  // Status built from the freshly updated values
  always_comb begin
    status_next = '0;
    status_next[counter_pkg::STATUS_CNT_LSB +: counter_pkg::CNT_WIDTH] = cnt_next;
    status_next[counter_pkg::STATUS_TICK_CNT_LSB +: counter_pkg::TICK_WIDTH] = tick_cnt_next;
    status_next[counter_pkg::STATUS_TICK_BIT] = (tick_cnt_next >= tick_value_q);
    status_next[counter_pkg::STATUS_WMARK_BIT] = (cnt_next >= wmark_q);
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_cnt_q <= '0;
      cnt_q      <= '0;
      status_q   <= '0;
    end else begin
      tick_cnt_q <= tick_cnt_next;
      cnt_q      <= cnt_next;
      status_q   <= status_next;
    end
  end

  // ----------------------------------------
  // Readback, zero-extended
  // ----------------------------------------
  always_comb begin
    rd_hit = 1'b1;
    case (rd_addr)
      ocl_bus_pkg::CNT_CTRL_REG_ADDR:   rd_data = ocl_bus_pkg::data_t'(ctrl_q);
      ocl_bus_pkg::CNT_TICK_REG_ADDR:   rd_data = ocl_bus_pkg::data_t'(tick_value_q);
      ocl_bus_pkg::CNT_LOAD_REG_ADDR:   rd_data = ocl_bus_pkg::data_t'(load_value_q);
      ocl_bus_pkg::CNT_WMARK_REG_ADDR:  rd_data = ocl_bus_pkg::data_t'(wmark_q);
      ocl_bus_pkg::CNT_STATUS_REG_ADDR: rd_data = status_q;
      default: begin
        rd_data = '0;
        rd_hit  = 1'b0;
      end
    endcase
  end

endmodule

// ==== logic/hello_world_top.sv ====
`timescale 1ns/1ps

module hello_world_top #(
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic               clk_main_a0,
  input  logic               rst_main_n_sync,
  // OCL write address
  input  logic               ocl_awvalid,
  input  ocl_bus_pkg::addr_t ocl_awaddr,
  output logic               ocl_awready,
  // OCL write data
  input  logic               ocl_wvalid,
  input  ocl_bus_pkg::data_t ocl_wdata,
  input  ocl_bus_pkg::strb_t ocl_wstrb,
  output logic               ocl_wready,
  // OCL write response
  output logic               ocl_bvalid,
  output ocl_bus_pkg::resp_t ocl_bresp,
  input  logic               ocl_bready,
  // OCL read address
  input  logic               ocl_arvalid,
  input  ocl_bus_pkg::addr_t ocl_araddr,
  output logic               ocl_arready,
  // OCL read data
  output logic               ocl_rvalid,
  output ocl_bus_pkg::data_t ocl_rdata,
  output ocl_bus_pkg::resp_t ocl_rresp,
  input  logic               ocl_rready,
  // Virtual switches and LEDs
  input  ocl_bus_pkg::led_t  vdip,
  output ocl_bus_pkg::led_t  vled
);

  // Register-side strobes from the slave
  logic               wr_en;
  ocl_bus_pkg::addr_t wr_addr;
  ocl_bus_pkg::data_t wr_data;
  ocl_bus_pkg::addr_t rd_addr;

  // Read results per block
  ocl_bus_pkg::data_t regs_rd_data;
  logic               regs_rd_hit;
  ocl_bus_pkg::data_t cnt_rd_data;
  logic               cnt_rd_hit;

  // ----------------------------------------
  // Bus slave
  // ----------------------------------------
  ocl_slave u_ocl_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (ocl_awvalid),
    .awaddr          (ocl_awaddr),
    .awready         (ocl_awready),
    .wvalid          (ocl_wvalid),
    .wdata           (ocl_wdata),
    .wstrb           (ocl_wstrb),
    .wready          (ocl_wready),
    .bvalid          (ocl_bvalid),
    .bresp           (ocl_bresp),
    .bready          (ocl_bready),
    .arvalid         (ocl_arvalid),
    .araddr          (ocl_araddr),
    .arready         (ocl_arready),
    .rvalid          (ocl_rvalid),
    .rdata           (ocl_rdata),
    .rresp           (ocl_rresp),
    .rready          (ocl_rready),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_addr         (rd_addr),
    .regs_rd_data    (regs_rd_data),
    .regs_rd_hit     (regs_rd_hit),
    .cnt_rd_data     (cnt_rd_data),
    .cnt_rd_hit      (cnt_rd_hit)
  );

  // ----------------------------------------
  // Register blocks
  // ----------------------------------------
  hello_world_regs #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_hello_world_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_addr         (rd_addr),
    .rd_data         (regs_rd_data),
    .rd_hit          (regs_rd_hit),
    .vdip            (vdip),
    .vled            (vled)
  );

  // Software-driven counter
  tick_counter u_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_addr         (rd_addr),
    .rd_data         (cnt_rd_data),
    .rd_hit          (cnt_rd_hit)
  );

endmodule

// ==== test/hello_world_tb.sv ====
`timescale 1ns/1ps

module hello_world_tb;

  localparam int unsigned TIMEOUT_CYCLES = 50;
  localparam int unsigned POLL_LIMIT     = 20;

  logic               clk_main_a0;
  logic               rst_main_n_sync;
  logic               ocl_awvalid;
  ocl_bus_pkg::addr_t ocl_awaddr;
  logic               ocl_awready;
  logic               ocl_wvalid;
  ocl_bus_pkg::data_t ocl_wdata;
  ocl_bus_pkg::strb_t ocl_wstrb;
  logic               ocl_wready;
  logic               ocl_bvalid;
  ocl_bus_pkg::resp_t ocl_bresp;
  logic               ocl_bready;
  logic               ocl_arvalid;
  ocl_bus_pkg::addr_t ocl_araddr;
  logic               ocl_arready;
  logic               ocl_rvalid;
  ocl_bus_pkg::data_t ocl_rdata;
  ocl_bus_pkg::resp_t ocl_rresp;
  logic               ocl_rready;
  ocl_bus_pkg::led_t  vdip;
  ocl_bus_pkg::led_t  vled;

  int unsigned errors;
  int unsigned checks;
  logic [31:0] lfsr_state;

  hello_world_top #(
    .SYNC_STAGES (2)
  ) DUT (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ocl_awvalid     (ocl_awvalid),
    .ocl_awaddr      (ocl_awaddr),
    .ocl_awready     (ocl_awready),
    .ocl_wvalid      (ocl_wvalid),
    .ocl_wdata       (ocl_wdata),
    .ocl_wstrb       (ocl_wstrb),
    .ocl_wready      (ocl_wready),
    .ocl_bvalid      (ocl_bvalid),
    .ocl_bresp       (ocl_bresp),
    .ocl_bready      (ocl_bready),
    .ocl_arvalid     (ocl_arvalid),
    .ocl_araddr      (ocl_araddr),
    .ocl_arready     (ocl_arready),
    .ocl_rvalid      (ocl_rvalid),
    .ocl_rdata       (ocl_rdata),
    .ocl_rresp       (ocl_rresp),
    .ocl_rready      (ocl_rready),
    .vdip            (vdip),
    .vled            (vled)
  );

  // 20 ns clock
  initial begin
    clk_main_a0 = 1'b0;
    forever #10 clk_main_a0 = ~clk_main_a0;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // Fibonacci LFSR with taps 32 22 2 1, stepped once per bit
  function automatic logic [31:0] lfsr_bits(input int unsigned count);
    logic [31:0] result;
    logic        feedback;
    result = '0;
    for (int unsigned i = 0; i < count; i++) begin
      feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], feedback};
      result     = {result[30:0], feedback};
    end
    return result;
  endfunction

  // Byte 0 swaps with byte 3, byte 1 with byte 2
  function automatic logic [31:0] byte_reverse(input logic [31:0] word);
    logic [31:0] result;
    for (int i = 0; i < 4; i++) begin
      result[8*i +: 8] = word[8*(3-i) +: 8];
    end
    return result;
  endfunction

  function automatic logic is_mapped(input logic [31:0] addr);
    return (addr == 32'h500) || (addr == 32'h504) || (addr == 32'h510) ||
           (addr == 32'h514) || (addr == 32'h518) || (addr == 32'h51C) ||
           (addr == 32'h520);
  endfunction

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("** Error at %0t: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("At %0t: %s", $time, what);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("At %0t: timed out waiting for %s", $time, what);
  endtask

  // Drop every handshake after a stuck transfer
  task automatic release_bus();
    @(posedge clk_main_a0);
    ocl_awvalid <= 1'b0;
    ocl_wvalid  <= 1'b0;
    ocl_bready  <= 1'b0;
    ocl_arvalid <= 1'b0;
    ocl_rready  <= 1'b0;
  endtask

  // ----------------------------------------
  // Bus transfers
  // ----------------------------------------
  task automatic bus_write(input ocl_bus_pkg::addr_t addr, input ocl_bus_pkg::data_t data);
    int unsigned waited;
    @(posedge clk_main_a0);
    ocl_awvalid <= 1'b1;
    ocl_awaddr  <= addr;
    ocl_wvalid  <= 1'b1;
    ocl_wdata   <= data;
    ocl_wstrb   <= '1;
    ocl_bready  <= 1'b1;
    // Address accepted on the edge after awready is seen
    waited = 0;
    @(negedge clk_main_a0);
    while (!ocl_awready && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_main_a0);
      waited++;
    end
    if (!ocl_awready) begin
      report_timeout("awready");
      release_bus();
      return;
    end
    @(posedge clk_main_a0);
    ocl_awvalid <= 1'b0;
    // Data beat
    waited = 0;
    @(negedge clk_main_a0);
    while (!ocl_wready && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_main_a0);
      waited++;
    end
    if (!ocl_wready) begin
      report_timeout("wready");
      release_bus();
      return;
    end
    @(posedge clk_main_a0);
    ocl_wvalid <= 1'b0;
    // Response with bready already high
    waited = 0;
    @(negedge clk_main_a0);
    while (!ocl_bvalid && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_main_a0);
      waited++;
    end
    if (!ocl_bvalid) begin
      report_timeout("bvalid");
      release_bus();
      return;
    end
    check_equal("ocl_bresp", 32'(ocl_bus_pkg::RESP_OKAY), 32'(ocl_bresp));
    @(posedge clk_main_a0);
    ocl_bready <= 1'b0;
  endtask

  // hold > 0 keeps rready low that many cycles after rvalid
  task automatic bus_read(input ocl_bus_pkg::addr_t addr, input int unsigned hold,
                          output ocl_bus_pkg::data_t data);
    int unsigned waited;
    data = '0;
    @(posedge clk_main_a0);
    ocl_arvalid <= 1'b1;
    ocl_araddr  <= addr;
    ocl_rready  <= (hold == 0);
    waited = 0;
    @(negedge clk_main_a0);
    while (!ocl_arready && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_main_a0);
      waited++;
    end
    if (!ocl_arready) begin
      report_timeout("arready");
      release_bus();
      return;
    end
    @(posedge clk_main_a0);
    ocl_arvalid <= 1'b0;
    waited = 0;
    @(negedge clk_main_a0);
    while (!ocl_rvalid && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_main_a0);
      waited++;
    end
    if (!ocl_rvalid) begin
      report_timeout("rvalid");
      release_bus();
      return;
    end
    data = ocl_rdata;
    check_equal("ocl_rresp", 32'(ocl_bus_pkg::RESP_OKAY), 32'(ocl_rresp));
    // Stalled response must hold still
    for (int unsigned i = 0; i < hold; i++) begin
      @(negedge clk_main_a0);
      check_equal("ocl_rvalid", 32'd1, 32'(ocl_rvalid));
      check_equal("ocl_rdata", data, ocl_rdata);
      check_equal("ocl_arready", 32'd0, 32'(ocl_arready));
    end
    if (hold > 0) begin
      @(posedge clk_main_a0);
      ocl_rready <= 1'b1;
    end
    @(posedge clk_main_a0);
    ocl_rready <= 1'b0;
    // Idle data bus after the handshake
    @(negedge clk_main_a0);
    check_equal("ocl_rvalid", 32'd0, 32'(ocl_rvalid));
    check_equal("ocl_rdata", 32'd0, ocl_rdata);
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_hello_readback();
    ocl_bus_pkg::data_t word;
    ocl_bus_pkg::data_t rd;
    for (int i = 0; i < 4; i++) begin
      word = lfsr_bits(32);
      bus_write(ocl_bus_pkg::HELLO_WORLD_REG_ADDR, word);
      bus_read(ocl_bus_pkg::HELLO_WORLD_REG_ADDR, 0, rd);
      check_equal("hello_world readback", byte_reverse(word), rd);
    end
  endtask

  task automatic test_led_path();
    ocl_bus_pkg::data_t word;
    ocl_bus_pkg::data_t rd;
    logic [31:0]        bits;
    ocl_bus_pkg::led_t  shadow;
    ocl_bus_pkg::led_t  pattern;
    ocl_bus_pkg::led_t  old_led;
    ocl_bus_pkg::led_t  new_led;
    int unsigned        waited;
    word   = lfsr_bits(32);
    shadow = word[15:0];
    bus_write(ocl_bus_pkg::HELLO_WORLD_REG_ADDR, word);
    // All switches on, so LEDs follow the shadow
    waited = 0;
    @(negedge clk_main_a0);
    while (vled != shadow && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_main_a0);
      waited++;
    end
    if (vled != shadow) begin
      report_timeout("vled to follow the hello-world write");
    end
    bus_read(ocl_bus_pkg::VLED_REG_ADDR, 0, rd);
    check_equal("vled readback", {16'h0000, shadow}, rd);
    // New switch pattern through the synchronizer
    bits    = lfsr_bits(16);
    pattern = bits[15:0];
    old_led = vled;
    new_led = shadow & pattern;
    @(posedge clk_main_a0);
    vdip <= pattern;
    waited = 0;
    @(negedge clk_main_a0);
    while (vled != new_led && waited < TIMEOUT_CYCLES) begin
      check_true("vled showed a value other than old, new or zero",
                 (vled == old_led) || (vled == '0));
      @(negedge clk_main_a0);
      waited++;
    end
    if (vled != new_led) begin
      report_timeout("vled to follow the new vdip pattern");
    end
  endtask

  task automatic test_unmapped_and_config();
    ocl_bus_pkg::addr_t addr;
    ocl_bus_pkg::data_t rd;
    logic [31:0]        value;
    for (int i = 0; i < 4; i++) begin
      addr = lfsr_bits(32);
      // Register map never sets bit 12
      if (is_mapped(addr)) begin
        addr[12] = ~addr[12];
      end
      bus_read(addr, 0, rd);
      check_equal("unmapped readback", 32'hDEAD_BEEF, rd);
    end
    // Gaps inside and just past the map
    bus_read(32'h508, 0, rd);
    check_equal("unmapped 0x508", 32'hDEAD_BEEF, rd);
    bus_read(32'h524, 0, rd);
    check_equal("unmapped 0x524", 32'hDEAD_BEEF, rd);
    value = lfsr_bits(8);
    bus_write(ocl_bus_pkg::CNT_TICK_REG_ADDR, value);
    bus_read(ocl_bus_pkg::CNT_TICK_REG_ADDR, 0, rd);
    check_equal("tick value readback", value, rd);
    value = lfsr_bits(16);
    bus_write(ocl_bus_pkg::CNT_LOAD_REG_ADDR, value);
    bus_read(ocl_bus_pkg::CNT_LOAD_REG_ADDR, 0, rd);
    check_equal("load value readback", value, rd);
    value = lfsr_bits(16);
    bus_write(ocl_bus_pkg::CNT_WMARK_REG_ADDR, value);
    bus_read(ocl_bus_pkg::CNT_WMARK_REG_ADDR, 0, rd);
    check_equal("watermark readback", value, rd);
    value = lfsr_bits(4);
    bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR, value);
    bus_read(ocl_bus_pkg::CNT_CTRL_REG_ADDR, 0, rd);
    check_equal("control readback", value, rd);
    bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR, 32'd0);
  endtask

  task automatic test_counter_load_clear();
    logic [31:0]        load;
    logic [31:0]        wmark;
    ocl_bus_pkg::data_t status;
    // Prescaler runs a few cycles from zero, then holds a nonzero count
    bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR, 32'd1 << counter_pkg::CTRL_CLEAR_BIT);
    bus_write(ocl_bus_pkg::CNT_TICK_REG_ADDR, 32'h0000_00FF);
    bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR, 32'd1 << counter_pkg::CTRL_ENABLE_BIT);
    for (int i = 0; i < 2; i++) begin
      load = lfsr_bits(16);
      // Second pass lands exactly on the watermark
      wmark = (i == 0) ? lfsr_bits(16) : load;
      bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR, 32'd0);
      bus_write(ocl_bus_pkg::CNT_LOAD_REG_ADDR, load);
      bus_write(ocl_bus_pkg::CNT_WMARK_REG_ADDR, wmark);
      bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR, 32'd1 << counter_pkg::CTRL_LOAD_BIT);
      bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR, 32'd0);
      bus_read(ocl_bus_pkg::CNT_STATUS_REG_ADDR, 0, status);
      check_equal("status count", load, {16'h0000, status[15:0]});
      check_equal("status watermark flag", 32'(load >= wmark), 32'(status[25]));
      check_equal("status unused bits", 32'd0, 32'(status[31:26]));
      check_true("tick count was zero before the clear", status[23:16] != 8'd0);
    end
    bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR, 32'd1 << counter_pkg::CTRL_CLEAR_BIT);
    bus_read(ocl_bus_pkg::CNT_STATUS_REG_ADDR, 0, status);
    check_equal("status count after clear", 32'd0, 32'(status[15:0]));
    check_equal("status tick count after clear", 32'd0, 32'(status[23:16]));
    bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR, 32'd0);
  endtask

  task automatic test_counter_run();
    ocl_bus_pkg::data_t first;
    ocl_bus_pkg::data_t second;
    ocl_bus_pkg::data_t status;
    int unsigned        polls;
    // Tick value 0 gives a tick every cycle
    bus_write(ocl_bus_pkg::CNT_TICK_REG_ADDR, 32'd0);
    bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR, 32'd1 << counter_pkg::CTRL_ENABLE_BIT);
    bus_read(ocl_bus_pkg::CNT_STATUS_REG_ADDR, 0, first);
    bus_read(ocl_bus_pkg::CNT_STATUS_REG_ADDR, 0, second);
    check_true("count did not increase between status reads", second[15:0] > first[15:0]);
    // One-shot from just below the top
    bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR, 32'd0);
    bus_write(ocl_bus_pkg::CNT_LOAD_REG_ADDR, 32'h0000_FFF0);
    bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR, 32'd1 << counter_pkg::CTRL_LOAD_BIT);
    bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR,
              (32'd1 << counter_pkg::CTRL_ENABLE_BIT) | (32'd1 << counter_pkg::CTRL_ONESHOT_BIT));
    polls = 0;
    status = '0;
    while (status[15:0] != 16'hFFFF && polls < POLL_LIMIT) begin
      bus_read(ocl_bus_pkg::CNT_STATUS_REG_ADDR, 0, status);
      polls++;
    end
    if (status[15:0] != 16'hFFFF) begin
      report_timeout("one-shot count to reach 0xFFFF");
    end
    for (int i = 0; i < 2; i++) begin
      bus_read(ocl_bus_pkg::CNT_STATUS_REG_ADDR, 0, status);
      check_equal("one-shot status count", 32'h0000_FFFF, {16'h0000, status[15:0]});
    end
    // Free-running from the same load wraps
    bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR, 32'd0);
    bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR, 32'd1 << counter_pkg::CTRL_LOAD_BIT);
    bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR, 32'd1 << counter_pkg::CTRL_ENABLE_BIT);
    polls = 0;
    status = 32'h0000_FFFF;
    while (status[15:0] >= 16'hFFF0 && polls < POLL_LIMIT) begin
      bus_read(ocl_bus_pkg::CNT_STATUS_REG_ADDR, 0, status);
      polls++;
    end
    if (status[15:0] >= 16'hFFF0) begin
      report_timeout("free-running count to wrap");
    end
    bus_write(ocl_bus_pkg::CNT_CTRL_REG_ADDR, 32'd0);
  endtask

  task automatic test_read_backpressure();
    ocl_bus_pkg::data_t word;
    ocl_bus_pkg::data_t rd;
    word = lfsr_bits(32);
    bus_write(ocl_bus_pkg::HELLO_WORLD_REG_ADDR, word);
    bus_read(ocl_bus_pkg::HELLO_WORLD_REG_ADDR, 6, rd);
    check_equal("stalled hello_world readback", byte_reverse(word), rd);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    errors          = 0;
    checks          = 0;
    lfsr_state      = 32'd94791;
    rst_main_n_sync = 1'b0;
    ocl_awvalid     = 1'b0;
    ocl_awaddr      = '0;
    ocl_wvalid      = 1'b0;
    ocl_wdata       = '0;
    ocl_wstrb       = '0;
    ocl_bready      = 1'b0;
    ocl_arvalid     = 1'b0;
    ocl_araddr      = '0;
    ocl_rready      = 1'b0;
    // Switches all on
    vdip            = '1;
    repeat (3) @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;
    @(negedge clk_main_a0);
    check_equal("ocl_awready after reset", 32'd1, 32'(ocl_awready));
    check_equal("ocl_arready after reset", 32'd1, 32'(ocl_arready));
    check_equal("vled after reset", 32'd0, 32'(vled));
    test_hello_readback();
    test_led_path();
    test_unmapped_and_config();
    test_counter_load_clear();
    test_counter_run();
    test_read_backpressure();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== hello_world_top.f ====
logic/ocl_bus_pkg.sv
logic/counter_pkg.sv
logic/ocl_slave.sv
logic/hello_world_regs.sv
logic/tick_counter.sv
logic/hello_world_top.sv
test/hello_world_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module hello_world_tb \
  -f hello_world_top.f -o sim_hello_world \
  && ./obj_dir/sim_hello_world > "$LOG" 2>&1 \
  || { cat "$LOG" 2>/dev/null; echo "Build or run failed"; exit 1; }

cat "$LOG"
grep -q "All tests passed" "$LOG" && echo "PASS" || { echo "FAIL"; exit 1; }
